// File: build.f
sscPkg.sv
decRvSscFlag.sv
fetchWindowReg.sv
bundleHazard.sv
bundleFormer.sv
laneIssue.sv
sscBundleTop.sv
tbSscBundle.sv

// File: tbSscBundle.sv
/*
 tbSscBundle drives the three-lane issue bundle former.
 directed and random windows checked against a lane-flag and width model
*/
`timescale 1ns/1ps

module tbSscBundle;
  import sscPkg::*;

  localparam bit USE_LANE3 = 1'b1;
  localparam logic [6:0] LOAD = 7'b0000011;
  localparam logic [6:0] STORE = 7'b0100011;
  localparam logic [6:0] FPSTORE = 7'b0100111;
  localparam logic [6:0] BRANCH = 7'b1100011;
  localparam logic [6:0] JAL = 7'b1101111;
  localparam logic [6:0] OPIMM = 7'b0010011;
  localparam logic [6:0] OP = 7'b0110011;
  localparam logic [6:0] LUI = 7'b0110111;
  localparam logic [6:0] OPFP = 7'b1010011;
  localparam logic [6:0] SYSTEM = 7'b1110011;

  logic         clock;
  logic         arstN;
  logic         winValid;
  fetchWin_t    window;
  logic         bundleValid;
  issueBundle_t bundle;

  int           errCount;
  int           testBase;
  int           cycle;
  int           strobes;
  int           pulses;
  issueBundle_t expQ[$];
  int           dueQ[$];
  issueBundle_t monExp;
  int           monDue;

  sscBundleTop #(.USE_LANE3(USE_LANE3)) u_dut (
    .clock       (clock),
    .arstN       (arstN),
    .winValid    (winValid),
    .window      (window),
    .bundleValid (bundleValid),
    .bundle      (bundle)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  task automatic checkEq(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  function automatic rvInstr_u mkWord(input logic [6:0] opc, input logic [4:0] rd,
      input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2, input logic [6:0] f7);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic fetchWin_t mkWin(input rvInstr_u a, input rvInstr_u b, input rvInstr_u c,
      input logic [1:0] cnt);
    fetchWin_t w;
    w.slot[0] = a;
    w.slot[1] = b;
    w.slot[2] = c;
    w.count   = cnt;
    w.pc      = cnt - 2'd1;
    return w;
  endfunction

  // lane flags from the opcode class table
  function automatic logic [3:0] flagsOf(input rvInstr_u w);
    logic [2:0] f3;
    f3 = w.rType.funct3;
    if (w.raw[1:0] != 2'b11) return 4'b0000;
    case (w.rType.opcode)
      LOAD:    return (f3 == 3'd7) ? 4'b0000 : 4'b0011;
      STORE:   return (f3 == 3'd7) ? 4'b0000 : 4'b0001;
      OPIMM: begin
        if (f3 == 3'd1 || f3 == 3'd5) return (w.raw[29:26] != 4'd0) ? 4'b0000 : 4'b0111;
        if (f3 == 3'd2 || f3 == 3'd3) return 4'b0011;
        return 4'b1111;
      end
      OP: begin
        if (w.rType.funct7[4:0] != 5'd0) return 4'b0000;
        return (f3 == 3'd2 || f3 == 3'd3) ? 4'b0011 : 4'b1111;
      end
      LUI, OPFP: return 4'b0011;
      default: return 4'b0000;
    endcase
  endfunction

  // stores write nothing and x0 is never a destination
  function automatic logic [4:0] destReg(input rvInstr_u w);
    if (w.rType.opcode == STORE || w.rType.opcode == FPSTORE) return 5'd0;
    return w.rType.rd;
  endfunction

  function automatic logic readsReg(input rvInstr_u w, input logic [4:0] r);
    return (r != 5'd0) && (w.rType.rs1 == r || w.rType.rs2 == r);
  endfunction

  function automatic issueBundle_t modelBundle(input fetchWin_t w);
    logic [3:0]   f0;
    logic [3:0]   f1;
    logic [3:0]   f2;
    logic [4:0]   d0;
    logic [4:0]   d1;
    logic [4:0]   d2;
    logic         two;
    logic         three;
    issueBundle_t b;
    f0 = flagsOf(w.slot[0]);
    f1 = flagsOf(w.slot[1]);
    f2 = flagsOf(w.slot[2]);
    d0 = destReg(w.slot[0]);
    d1 = destReg(w.slot[1]);
    d2 = destReg(w.slot[2]);
    two = (w.count >= 2) && f0[0] && f1[2] && !readsReg(w.slot[1], d0) &&
          !(d0 != 5'd0 && d0 == d1);
    three = two && USE_LANE3 && (w.count == 3) && f0[1] && f2[3] &&
            !readsReg(w.slot[2], d0) && !readsReg(w.slot[2], d1) &&
            !(d2 != 5'd0 && (d2 == d0 || d2 == d1));
    b.pc      = w.pc;
    b.lane[0] = w.slot[0];
    b.lane[1] = two ? w.slot[1] : '0;
    b.lane[2] = three ? w.slot[2] : '0;
    b.width   = three ? 2'd3 : (two ? 2'd2 : 2'd1);
    return b;
  endfunction

  // registers from x0..x3 so hazards are frequent
  function automatic rvInstr_u randWord();
    logic [6:0] opc;
    logic [6:0] f7;
    case ($urandom % 12)
      0: opc = LOAD;
      1: opc = STORE;
      2: opc = BRANCH;
      3: opc = JAL;
      4, 5: opc = OPIMM;
      6, 7: opc = OP;
      8: opc = LUI;
      9: opc = OPFP;
      10: opc = SYSTEM;
      // low bit cleared so not a 32-bit word
      default: opc = 7'($urandom) & 7'h7e;
    endcase
    case ($urandom % 4)
      0: f7 = 7'b0000000;
      1: f7 = 7'b0100000;
      2: f7 = 7'b0000001;
      default: f7 = 7'b0000010;
    endcase
    return mkWord(opc, 5'($urandom % 4), 3'($urandom), 5'($urandom % 4),
                  5'($urandom % 4), f7);
  endfunction

  // called 1 ns after a rising edge and returns 1 ns after the next
  task automatic sendWin(input fetchWin_t w, input int expW);
    issueBundle_t b;
    b = modelBundle(w);
    if (expW != 0) checkEq("directed width", b.width, expW);
    expQ.push_back(b);
    dueQ.push_back(cycle + 2);
    window   = w;
    winValid = 1'b1;
    strobes++;
    @(posedge clock);
    #1;
    winValid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic waitDrain();
    int n;
    n = 0;
    while (expQ.size() != 0 && n < 20) begin
      @(posedge clock);
      n++;
    end
    if (expQ.size() != 0) begin
      $display("timeout: %0d bundles never came out", expQ.size());
      errCount++;
      expQ.delete();
      dueQ.delete();
    end
    @(posedge clock);
    #1;
  endtask

  task automatic reportTest(input string name);
    $display("test %s done, %0d errors", name, errCount - testBase);
    testBase = errCount;
  endtask

  // scoreboard samples at the falling edge where outputs are settled
  always @(negedge clock) begin
    if (arstN && bundleValid) begin
      pulses++;
      if (expQ.size() == 0) begin
        $display("bundle pulse at %0t with no window strobed for it", $time);
        errCount++;
      end else begin
        monExp = expQ.pop_front();
        monDue = dueQ.pop_front();
        checkEq("bundle arrival cycle", cycle, monDue);
        checkEq("bundle.width", bundle.width, monExp.width);
        checkEq("bundle.lane", bundle.lane, monExp.lane);
        checkEq("bundle.pc", bundle.pc, monExp.pc);
      end
    end
  end

  initial begin
    rvInstr_u  cls[8];
    int        clsW[8];
    rvInstr_u  addi2;
    rvInstr_u  add1;
    rvInstr_u  indep;
    rvInstr_u  dep;
    fetchWin_t w;
    void'($urandom(15));
    clock    = 1'b0;
    arstN    = 1'b0;
    winValid = 1'b0;
    window   = '0;
    errCount = 0;
    testBase = 0;
    cycle    = 0;
    strobes  = 0;
    pulses   = 0;
    repeat (4) @(posedge clock);
    #1;
    arstN = 1'b1;

    // idle after reset
    repeat (3) begin
      @(negedge clock);
      checkEq("bundleValid", bundleValid, 1'b0);
      checkEq("bundle.width", bundle.width, 2'd1);
    end
    @(posedge clock);
    #1;
    reportTest("resetIdle");

    // one word per class alone and then paired with an independent addi
    cls[0] = mkWord(LOAD, 1, 2, 3, 0, 0);
    cls[1] = mkWord(LOAD, 1, 7, 3, 0, 0);
    cls[2] = mkWord(STORE, 1, 2, 3, 0, 0);
    cls[3] = mkWord(OPIMM, 1, 1, 3, 0, 0);
    cls[4] = mkWord(OPIMM, 1, 1, 3, 0, 7'b0000010);
    cls[5] = mkWord(BRANCH, 1, 0, 3, 0, 0);
    cls[6] = mkWord(7'b0010001, 1, 0, 3, 0, 0);
    cls[7] = mkWord(LUI, 1, 0, 3, 0, 0);
    clsW   = '{2, 1, 2, 2, 1, 1, 1, 2};
    addi2  = mkWord(OPIMM, 2, 0, 3, 0, 0);
    for (int i = 0; i < 8; i++) begin
      sendWin(mkWin(cls[i], '0, '0, 2'd1), 1);
      sendWin(mkWin(cls[i], addi2, '0, 2'd2), clsW[i]);
    end
    waitDrain();
    reportTest("opcodeClasses");

    // RAW, WAW and the store exception
    add1  = mkWord(OP, 1, 0, 2, 3, 0);
    indep = mkWord(OP, 2, 0, 3, 0, 0);
    dep   = mkWord(OP, 2, 0, 1, 0, 0);
    sendWin(mkWin(add1, indep, '0, 2'd2), 2);
    sendWin(mkWin(add1, dep, '0, 2'd2), 1);
    sendWin(mkWin(add1, mkWord(OP, 1, 0, 2, 3, 0), '0, 2'd2), 1);
    sendWin(mkWin(mkWord(STORE, 1, 2, 3, 0, 0), dep, '0, 2'd2), 2);
    waitDrain();
    reportTest("dependencySweep");

    // three-wide windows
    sendWin(mkWin(add1, indep, mkWord(OP, 3, 0, 0, 0, 0), 2'd3), 3);
    sendWin(mkWin(add1, indep, mkWord(OP, 3, 0, 1, 0, 0), 2'd3), 2);
    sendWin(mkWin(add1, indep, mkWord(OP, 2, 0, 0, 0, 0), 2'd3), 2);
    sendWin(mkWin(add1, indep, mkWord(OPIMM, 3, 2, 0, 0, 0), 2'd3), 2);
    sendWin(mkWin(mkWord(STORE, 1, 2, 3, 0, 0), indep, mkWord(OP, 3, 0, 0, 0, 0), 2'd3), 2);
    sendWin(mkWin(add1, indep, mkWord(OP, 3, 0, 0, 0, 0), 2'd2), 2);
    waitDrain();
    reportTest("threeWide");

    // back to back random windows with short gaps
    for (int i = 0; i < 400; i++) begin
      w    = mkWin(randWord(), randWord(), randWord(), 2'(1 + $urandom % 3));
      w.pc = 2'($urandom);
      sendWin(w, 0);
      if ($urandom % 4 == 0) idle(1 + $urandom % 2);
    end
    waitDrain();
    checkEq("pulse count", pulses, strobes);
    reportTest("randomWindows");

    $display("windows %0d, bundles %0d, errors %0d", strobes, pulses, errCount);
    if (errCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sscBundleTop.sv
/*
 sscBundleTop: three-lane issue bundle former.
 window register, combinational former, bundle register
*/
`timescale 1ns/1ps

module sscBundleTop #(
  parameter bit USE_LANE3 = 1'b1
) (
  input  logic                 clock,
  input  logic                 arstN,
  input  logic                 winValid,
  input  sscPkg::fetchWin_t    window,
  output logic                 bundleValid,
  output sscPkg::issueBundle_t bundle
);
  import sscPkg::*;

  logic         heldValid;
  fetchWin_t    heldWin;
  logic         formValid;
  issueBundle_t formBundle;

  // stage 1, capture the window
  fetchWindowReg u_winReg (
    .clock     (clock),
    .arstN     (arstN),
    .winValid  (winValid),
    .window    (window),
    .heldValid (heldValid),
    .heldWin   (heldWin)
  );

  // decode, hazard check, width pick
  bundleFormer #(
    .USE_LANE3 (USE_LANE3)
  ) u_former (
    .heldValid  (heldValid),
    .heldWin    (heldWin),
    .formValid  (formValid),
    .formBundle (formBundle)
  );

  // stage 2, present the bundle
  laneIssue u_issue (
    .clock       (clock),
    .arstN       (arstN),
    .formValid   (formValid),
    .formBundle  (formBundle),
    .bundleValid (bundleValid),
    .bundle      (bundle)
  );

endmodule

// File: laneIssue.sv
/*
 laneIssue is the output register for the formed lane bundle.
 one bundle per strobe with a one-cycle valid pulse
*/
`timescale 1ns/1ps

module laneIssue (
  input  logic                 clock,
  input  logic                 arstN,
  input  logic                 formValid,
  input  sscPkg::issueBundle_t formBundle,
  output logic                 bundleValid,
  output sscPkg::issueBundle_t bundle
);
  import sscPkg::*;

  logic [1:0]               widthQ;
  rvInstr_u [MAX_LANES-1:0] laneQ;
  logic [1:0]               pcQ;

  // valid pulse and a width that idles at 1
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      bundleValid <= 1'b0;
      widthQ      <= 2'd1;
    end else begin
      bundleValid <= formValid;
      if (formValid) begin
        widthQ <= formBundle.width;
      end
    end
  end

  // lane words and pc tag
  always_ff @(posedge clock) begin
    if (formValid) begin
      laneQ <= formBundle.lane;
      pcQ   <= formBundle.pc;
    end
  end

  assign bundle = '{lane: laneQ, width: widthQ, pc: pcQ};

  // issued width always names a real lane count
  assert property (
    @(posedge clock) disable iff (!arstN)
    bundleValid |-> (bundle.width != 2'd0)
  ) else $error("bundle width %0d out of range", bundle.width);

  // lanes past the width must be empty so the consumer sees no stale op
  assert property (
    @(posedge clock) disable iff (!arstN)
    bundleValid |->
      ((bundle.width >= 2'd2) || (bundle.lane[1].raw == 32'd0)) &&
      ((bundle.width == 2'd3) || (bundle.lane[2].raw == 32'd0))
  ) else $error("nonzero word in unused lane");

endmodule

// File: bundleFormer.sv
/*
 bundleFormer: picks the issue width for a held window.
 three flag decoders plus the hazard check, purely combinational
*/
`timescale 1ns/1ps

module bundleFormer #(
  parameter bit USE_LANE3 = 1'b1
) (
  input  logic                 heldValid,
  input  sscPkg::fetchWin_t    heldWin,
  output logic                 formValid,
  output sscPkg::issueBundle_t formBundle
);
  import sscPkg::*;

  laneFlag_t [MAX_LANES-1:0] slotFlag;
  logic                      pair01Ok;
  logic                      trio012Ok;
  logic                      canTwo;
  logic                      canThree;

  // one decoder per slot
  for (genvar i = 0; i < MAX_LANES; i++) begin : g_dec
    decRvSscFlag u_dec (
      .istrWord (heldWin.slot[i]),
      .istrFlag (slotFlag[i])
    );
  end

  bundleHazard u_hazard (
    .slot0     (heldWin.slot[0]),
    .slot1     (heldWin.slot[1]),
    .slot2     (heldWin.slot[2]),
    .pair01Ok  (pair01Ok),
    .trio012Ok (trio012Ok)
  );

  // width 2: second word present, both flags, no conflict
  assign canTwo = (heldWin.count >= 2'd2) &&
                  slotFlag[0].lane1With2 &&
                  slotFlag[1].lane2 &&
                  pair01Ok;

  // width 3: lane 3 built in, full window, lane-3 flags
  assign canThree = canTwo && USE_LANE3 &&
                    (heldWin.count == 2'd3) &&
                    slotFlag[0].lane1With3 &&
                    slotFlag[2].lane3 &&
                    trio012Ok;

  always_comb begin
    formBundle.pc      = heldWin.pc;
    formBundle.lane[0] = heldWin.slot[0];
    // unused lanes carry word zero
    formBundle.lane[1] = canTwo ? heldWin.slot[1] : '0;
    formBundle.lane[2] = canThree ? heldWin.slot[2] : '0;
    if (canThree) begin
      formBundle.width = 2'd3;
    end else if (canTwo) begin
      formBundle.width = 2'd2;
    end else begin
      formBundle.width = 2'd1;
    end
  end

  // strobe passes straight through
  assign formValid = heldValid;

endmodule

// File: bundleHazard.sv
/*
 bundleHazard: register-dependency check across the three window slots.
 flags RAW and WAW conflicts, conservative on reads
*/
`timescale 1ns/1ps

module bundleHazard (
  input  sscPkg::rvInstr_u slot0,
  input  sscPkg::rvInstr_u slot1,
  input  sscPkg::rvInstr_u slot2,
  output logic             pair01Ok,
  output logic             trio012Ok
);
  import sscPkg::*;

  // destination of a slot, 0 when it writes nothing
  function automatic logic [4:0] destOf(input rvInstr_u s);
    logic isStore;
    isStore = (s.rType.opcode == OP_STORE) || (s.rType.opcode == OP_FPSTORE);
    return isStore ? 5'd0 : s.rType.rd;
  endfunction

  // rs1 and rs2 always count as reads
  // int and fp files share one name space here
  function automatic logic readsReg(input rvInstr_u s, input logic [4:0] r);
    return (r != 5'd0) && ((s.rType.rs1 == r) || (s.rType.rs2 == r));
  endfunction

  logic [4:0] dst0;
  logic [4:0] dst1;
  logic [4:0] dst2;
  logic       raw01;
  logic       waw01;
  logic       raw2;
  logic       waw2;

  assign dst0 = destOf(slot0);
  assign dst1 = destOf(slot1);
  assign dst2 = destOf(slot2);

  // slot 1 against slot 0
  assign raw01 = readsReg(slot1, dst0);
  assign waw01 = (dst0 != 5'd0) && (dst0 == dst1);

  // slot 2 against both older slots
  assign raw2 = readsReg(slot2, dst0) || readsReg(slot2, dst1);
  assign waw2 = (dst2 != 5'd0) && ((dst2 == dst0) || (dst2 == dst1));

  assign pair01Ok  = !raw01 && !waw01;
  // three-wide also needs the pair to be clean
  assign trio012Ok = pair01Ok && !raw2 && !waw2;

endmodule

// File: fetchWindowReg.sv
/*
 fetchWindowReg is the input-side register for the fetch window.
 it captures the window on its strobe and pulses heldValid a cycle later
*/
`timescale 1ns/1ps

module fetchWindowReg (
  input  logic              clock,
  input  logic              arstN,
  input  logic              winValid,
  input  sscPkg::fetchWin_t window,
  output logic              heldValid,
  output sscPkg::fetchWin_t heldWin
);

  // one valid strobe per accepted window
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      heldValid <= 1'b0;
    end else begin
      heldValid <= winValid;
    end
  end

  // window payload
  // holds its last value between strobes
  always_ff @(posedge clock) begin
    if (winValid) begin
      heldWin <= window;
    end
  end

  // fetch must never strobe an empty window
  // count 0 would let the former issue a stale slot 0
  assert property (
    @(posedge clock) disable iff (!arstN)
    winValid |-> window.count != 2'd0
  ) else $error("fetch window strobed with count 0");

endmodule

// File: decRvSscFlag.sv
/*
 decRvSscFlag: lane-eligibility decoder for one 32-bit RISC-V word.
 opcode, funct3 and funct7 bits give the four lane flags
*/
`timescale 1ns/1ps

module decRvSscFlag (
  input  sscPkg::rvInstr_u  istrWord,
  output sscPkg::laneFlag_t istrFlag
);
  import sscPkg::*;

  laneFlag_t  flags;
  logic [2:0] f3;

  assign f3       = istrWord.raw[14:12];
  assign istrFlag = flags;

  always_comb begin
    flags = 4'b0000;
    case (istrWord.raw[6:2])
      // LOAD, lanes 1 only
      5'b00000: begin
        flags = 4'b0011;
        // wide funct3 form stays alone
        if (f3 == 3'b111) begin
          flags = 4'b0000;
        end
      end
      // STORE, lane 1 paired with lane 2 only
      OP_STORE[6:2]: begin
        flags = 4'b0001;
        if (f3 == 3'b111) begin
          flags = 4'b0000;
        end
      end
      // FP load
      5'b00001: begin
        flags = 4'b0011;
        if (istrWord.raw[14]) begin
          flags = 4'b0000;
        end
      end
      // FP store
      OP_FPSTORE[6:2]: begin
        flags = 4'b0001;
        if (istrWord.raw[14]) begin
          flags = 4'b0000;
        end
      end
      // fused multiply-add family, issued alone
      5'b10000, 5'b10001, 5'b10010, 5'b10011: begin
        flags = 4'b0000;
      end
      // branch, jalr, jal
      5'b11000, 5'b11001, 5'b11011: begin
        flags = 4'b0000;
      end
      // fence, atomics, system
      5'b00011, 5'b01011, 5'b11100: begin
        flags = 4'b0000;
      end
      // ALU register-immediate
      5'b00100: begin
        flags = 4'b1111;
        // shifts, not lane 3
        if (f3 == 3'b001 || f3 == 3'b101) begin
          flags = 4'b0111;
          // nonstandard shift encodings
          if (istrWord.raw[29:26] != 4'd0) begin
            flags = 4'b0000;
          end
        end
        // slti/sltiu
        if (f3[2:1] == 2'b01) begin
          flags = 4'b0011;
        end
      end
      // ALU register-register, plain funct7 only
      5'b01100: begin
        flags = 4'b0000;
        if (istrWord.raw[29:25] == 5'd0) begin
          flags = 4'b1111;
          if (f3[2:1] == 2'b01) begin
            flags = 4'b0011;
          end
        end
      end
      // ALU register-immediate, 32-bit forms
      5'b00110: begin
        flags = 4'b1111;
        if (f3 == 3'b001 || f3 == 3'b101) begin
          flags = 4'b0111;
          if (istrWord.raw[29:26] != 4'd0) begin
            flags = 4'b0000;
          end
        end
        if (f3[2:1] == 2'b01 || f3[2:1] == 2'b11) begin
          flags = 4'b0011;
        end
        if (f3 == 3'b100) begin
          flags = 4'b0000;
        end
      end
      // ALU register-register, 32-bit forms
      5'b01110: begin
        flags = 4'b0000;
        if (istrWord.raw[29:25] == 5'd0) begin
          flags = 4'b1111;
          if (f3[2:1] == 2'b01) begin
            flags = 4'b0011;
          end
        end
      end
      // FPU op
      5'b10100: begin
        flags = 4'b0011;
      end
      // AUIPC needs the pc, alone
      5'b00101: begin
        flags = 4'b0000;
      end
      // LUI
      5'b01101: begin
        flags = 4'b0011;
      end
      default: begin
        flags = 4'b0000;
      end
    endcase

    // not a 32-bit word, no lane flags
    if (istrWord.raw[1:0] != 2'b11) begin
      flags = 4'b0000;
    end
  end

endmodule

// File: sscPkg.sv
/*
 sscPkg: shared types for the three-lane RISC-V issue bundle former.
 instruction union, lane-eligibility flags, window and bundle records
*/
package sscPkg;

  // lanes in one issue bundle
  localparam int MAX_LANES = 3;

  // major opcodes where bits 11:7 are immediate bits, not rd
  localparam logic [6:0] OP_STORE   = 7'b0100011;
  localparam logic [6:0] OP_FPSTORE = 7'b0100111;

  // register-field view of one 32-bit word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rType_t;

  // one instruction word
  // raw for the flag decoder, rType for the hazard check
  typedef union packed {
    logic [31:0] raw;
    rType_t      rType;
  } rvInstr_u;

  // lane-eligibility flags, lane1With2 is bit 0
  typedef struct packed {
    // may run in lane 3
    logic lane3;
    // may run in lane 2
    logic lane2;
    // may sit in lane 1 with a third op in lane 3
    logic lane1With3;
    // may sit in lane 1 with a second op in lane 2
    logic lane1With2;
  } laneFlag_t;

  // fetch window, slot 0 is the oldest word
  typedef struct packed {
    rvInstr_u [MAX_LANES-1:0] slot;
    // valid words, 1 to 3
    logic [1:0]               count;
    // low word-index tag, carried through untouched
    logic [1:0]               pc;
  } fetchWin_t;

  // issued lane bundle
  typedef struct packed {
    rvInstr_u [MAX_LANES-1:0] lane;
    // issued words, 1 to 3
    logic [1:0]               width;
    logic [1:0]               pc;
  } issueBundle_t;

endpackage
